// File: design/vmul_cfg_pkg.sv
// Multiply unit configuration: word and queue sizes, pipeline latency, element widths
package vmul_cfg_pkg;

  localparam int unsigned ElenWidth        = 64;
  localparam int unsigned StrbWidth        = ElenWidth / 8;
  localparam int unsigned VInsnQueueDepth  = 4;
  localparam int unsigned ResultQueueDepth = 2;
  localparam int unsigned MulLatency       = 2;
  localparam int unsigned NrVInsn          = 8;
  localparam int unsigned VlWidth          = 7;
  localparam int unsigned VrfAddrWidth     = 8;
  localparam int unsigned WordsPerReg      = 8;

  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vsew_e;

  typedef logic [ElenWidth-1:0] elen_t;
  typedef logic [StrbWidth-1:0] strb_t;

  // Elements carried by the next word, given the elements still left
  function automatic logic [VlWidth-1:0] word_elems(vsew_e vsew, logic [VlWidth-1:0] remaining);
    logic [VlWidth-1:0] per_word;
    per_word = VlWidth'(8) >> vsew;
    return (remaining < per_word) ? remaining : per_word;
  endfunction

endpackage

// File: design/vmul_op_pkg.sv
// Multiply unit operations: opcodes and the bundles passed between its stages
package vmul_op_pkg;

  typedef enum logic [1:0] {
    VMUL   = 2'd0,
    VMULHU = 2'd1,
    VMACC  = 2'd2
  } vmul_op_e;

  // One vector instruction as accepted from the lane sequencer
  typedef struct packed {
    logic [$clog2(vmul_cfg_pkg::NrVInsn)-1:0] id;
    vmul_op_e                                 op;
    vmul_cfg_pkg::vsew_e                      vsew;
    logic [vmul_cfg_pkg::VlWidth-1:0]         vl;
    logic [4:0]                               vd;
    logic                                     use_scalar;
    vmul_cfg_pkg::elen_t                      scalar_op;
  } vinsn_t;

  // Source words of one issue step
  typedef struct packed {
    vmul_cfg_pkg::elen_t vs1;
    vmul_cfg_pkg::elen_t vs2;
    vmul_cfg_pkg::elen_t vd;
  } operand_t;

  // A is vs1 or the replicated scalar, B is vs2, C is the accumulator
  typedef struct packed {
    vmul_op_e            op;
    vmul_cfg_pkg::elen_t a;
    vmul_cfg_pkg::elen_t b;
    vmul_cfg_pkg::elen_t c;
  } mul_req_t;

  // One register file write
  typedef struct packed {
    logic [$clog2(vmul_cfg_pkg::NrVInsn)-1:0] id;
    logic [vmul_cfg_pkg::VrfAddrWidth-1:0]    addr;
    vmul_cfg_pkg::elen_t                      wdata;
    vmul_cfg_pkg::strb_t                      be;
  } result_t;

endpackage

// File: design/vmul_sequencer.sv
// Multiply unit sequencer: instruction queue with issue, processing and commit phases
`timescale 1ns/10ps

module vmul_sequencer (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  vmul_op_pkg::vinsn_t                 vinsn_i,
  input  logic                                vinsn_valid_i,
  output logic                                vinsn_ready_o,
  input  logic                                operand_valid_i,
  output logic                                operand_ready_o,
  input  logic                                unit_ready_i,
  output vmul_op_pkg::vinsn_t                 issue_vinsn_o,
  output logic                                issue_fire_o,
  output vmul_op_pkg::vinsn_t                 proc_vinsn_o,
  output logic [vmul_cfg_pkg::VlWidth-1:0]    proc_remaining_o,
  input  logic                                write_fire_i,
  input  logic                                commit_fire_i,
  output logic [vmul_cfg_pkg::NrVInsn-1:0]    done_o
);

  import vmul_cfg_pkg::*;
  import vmul_op_pkg::*;

  localparam int unsigned PntWidth = $clog2(VInsnQueueDepth);

  // Phase pointers, plus the instructions still owed by each phase
  typedef struct packed {
    logic [PntWidth-1:0] accept_pnt;
    logic [PntWidth-1:0] issue_pnt;
    logic [PntWidth-1:0] proc_pnt;
    logic [PntWidth-1:0] commit_pnt;
    logic [PntWidth:0]   issue_cnt;
    logic [PntWidth:0]   proc_cnt;
    logic [PntWidth:0]   commit_cnt;
  } queue_ptr_t;

  vinsn_t [VInsnQueueDepth-1:0] vinsn_d, vinsn_q;
  queue_ptr_t                   ptr_d, ptr_q;
  // Elements left in the instruction at the head of each phase
  logic [VlWidth-1:0]           issue_rem_d, issue_rem_q;
  logic [VlWidth-1:0]           proc_rem_d, proc_rem_q;
  logic [VlWidth-1:0]           commit_rem_d, commit_rem_q;
  vinsn_t                       commit_vinsn;
  logic                         accept;

  assign vinsn_ready_o    = (ptr_q.commit_cnt != VInsnQueueDepth);
  assign accept           = vinsn_valid_i && vinsn_ready_o;
  assign issue_vinsn_o    = vinsn_q[ptr_q.issue_pnt];
  assign proc_vinsn_o     = vinsn_q[ptr_q.proc_pnt];
  assign commit_vinsn     = vinsn_q[ptr_q.commit_pnt];
  assign proc_remaining_o = proc_rem_q;

  // Operands are consumed in the same cycle the step issues
  assign issue_fire_o    = (ptr_q.issue_cnt != '0) && operand_valid_i && unit_ready_i;
  assign operand_ready_o = issue_fire_o;

  always_comb begin
    vinsn_d      = vinsn_q;
    ptr_d        = ptr_q;
    issue_rem_d  = issue_rem_q;
    proc_rem_d   = proc_rem_q;
    commit_rem_d = commit_rem_q;
    done_o       = '0;

    if (issue_fire_o) begin
      issue_rem_d = issue_rem_q - word_elems(issue_vinsn_o.vsew, issue_rem_q);
      if (issue_rem_d == '0) begin
        ptr_d.issue_pnt = ptr_q.issue_pnt + 1'b1;
        ptr_d.issue_cnt = ptr_q.issue_cnt - 1'b1;
        if (ptr_d.issue_cnt != '0) issue_rem_d = vinsn_q[ptr_d.issue_pnt].vl;
      end
    end

    if (write_fire_i) begin
      proc_rem_d = proc_rem_q - word_elems(proc_vinsn_o.vsew, proc_rem_q);
      if (proc_rem_d == '0) begin
        ptr_d.proc_pnt = ptr_q.proc_pnt + 1'b1;
        ptr_d.proc_cnt = ptr_q.proc_cnt - 1'b1;
        if (ptr_d.proc_cnt != '0) proc_rem_d = vinsn_q[ptr_d.proc_pnt].vl;
      end
    end

    // Last grant of an instruction retires it and raises its done bit
    if (commit_fire_i) begin
      commit_rem_d = commit_rem_q - word_elems(commit_vinsn.vsew, commit_rem_q);
      if (commit_rem_d == '0) begin
        done_o[commit_vinsn.id] = 1'b1;
        ptr_d.commit_pnt = ptr_q.commit_pnt + 1'b1;
        ptr_d.commit_cnt = ptr_q.commit_cnt - 1'b1;
        if (ptr_d.commit_cnt != '0) commit_rem_d = vinsn_q[ptr_d.commit_pnt].vl;
      end
    end

    if (accept) begin
      vinsn_d[ptr_q.accept_pnt] = vinsn_i;
      // A phase with nothing pending starts on the new instruction
      if (ptr_d.issue_cnt == '0) issue_rem_d = vinsn_i.vl;
      if (ptr_d.proc_cnt == '0) proc_rem_d = vinsn_i.vl;
      if (ptr_d.commit_cnt == '0) commit_rem_d = vinsn_i.vl;
      ptr_d.accept_pnt = ptr_q.accept_pnt + 1'b1;
      ptr_d.issue_cnt  = ptr_d.issue_cnt + 1'b1;
      ptr_d.proc_cnt   = ptr_d.proc_cnt + 1'b1;
      ptr_d.commit_cnt = ptr_d.commit_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vinsn_q      <= '0;
      ptr_q        <= '0;
      issue_rem_q  <= '0;
      proc_rem_q   <= '0;
      commit_rem_q <= '0;
    end else begin
      vinsn_q      <= vinsn_d;
      ptr_q        <= ptr_d;
      issue_rem_q  <= issue_rem_d;
      proc_rem_q   <= proc_rem_d;
      commit_rem_q <= commit_rem_d;
    end
  end

endmodule

// File: design/vmul_operand_stage.sv
// Operand stage: scalar replication and steering of each request to its width's multiplier
`timescale 1ns/10ps

module vmul_operand_stage (
  input  vmul_op_pkg::vinsn_t   issue_vinsn_i,
  input  logic                  issue_fire_i,
  input  vmul_op_pkg::operand_t operand_i,
  output vmul_op_pkg::mul_req_t mul_req_o,
  output logic [3:0]            mul_valid_o,
  input  logic [3:0]            mul_ready_i,
  output logic                  unit_ready_o
);

  import vmul_cfg_pkg::*;
  import vmul_op_pkg::*;

  elen_t scalar_word;

  // Copy the scalar into every element of the word
  always_comb begin
    case (issue_vinsn_i.vsew)
      EW8:     scalar_word = {8{issue_vinsn_i.scalar_op[7:0]}};
      EW16:    scalar_word = {4{issue_vinsn_i.scalar_op[15:0]}};
      EW32:    scalar_word = {2{issue_vinsn_i.scalar_op[31:0]}};
      default: scalar_word = issue_vinsn_i.scalar_op;
    endcase
  end

  assign mul_req_o.op = issue_vinsn_i.op;
  assign mul_req_o.a  = issue_vinsn_i.use_scalar ? scalar_word : operand_i.vs1;
  assign mul_req_o.b  = operand_i.vs2;
  assign mul_req_o.c  = operand_i.vd;

  // Only the multiplier of this element width sees the request
  always_comb begin
    mul_valid_o                     = '0;
    mul_valid_o[issue_vinsn_i.vsew] = issue_fire_i;
  end

  assign unit_ready_o = mul_ready_i[issue_vinsn_i.vsew];

endmodule

// File: design/simd_mul.sv
// SIMD integer multiplier for one element width, pipelined with whole-pipe stall
`timescale 1ns/10ps

module simd_mul #(
  parameter vmul_cfg_pkg::vsew_e ElementWidth = vmul_cfg_pkg::EW64
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  vmul_op_pkg::mul_req_t req_i,
  input  logic                  valid_i,
  output logic                  ready_o,
  output vmul_cfg_pkg::elen_t   result_o,
  output logic                  valid_o,
  input  logic                  ready_i
);

  import vmul_cfg_pkg::*;

  localparam int unsigned EwBits  = 8 << ElementWidth;
  localparam int unsigned NrLanes = ElenWidth / EwBits;

  elen_t                  result_d;
  elen_t [MulLatency-1:0] data_q;
  logic  [MulLatency-1:0] valid_q;
  logic                   stall;

  // Independent lanes, each with a full double-width product
  always_comb begin : p_lanes
    logic [2*EwBits-1:0] prod;
    result_d = '0;
    prod     = '0;
    for (int l = 0; l < NrLanes; l++) begin
      prod = req_i.a[l*EwBits +: EwBits] * req_i.b[l*EwBits +: EwBits];
      case (req_i.op)
        vmul_op_pkg::VMULHU: result_d[l*EwBits +: EwBits] = prod[2*EwBits-1 -: EwBits];
        vmul_op_pkg::VMACC:
          result_d[l*EwBits +: EwBits] = req_i.c[l*EwBits +: EwBits] + prod[EwBits-1:0];
        default:             result_d[l*EwBits +: EwBits] = prod[EwBits-1:0];
      endcase
    end
  end

  // Output held back, so every stage keeps its item
  assign stall    = valid_q[MulLatency-1] && !ready_i;
  assign ready_o  = !stall;
  assign valid_o  = valid_q[MulLatency-1];
  assign result_o = data_q[MulLatency-1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (!stall) begin
      for (int s = MulLatency - 1; s > 0; s--) valid_q[s] <= valid_q[s-1];
      valid_q[0] <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall) begin
      for (int s = MulLatency - 1; s > 0; s--) data_q[s] <= data_q[s-1];
      data_q[0] <= result_d;
    end
  end

endmodule

// File: design/vmul_result_queue.sv
// Result queue: collects multiplier words and writes them to the register file with req/gnt
`timescale 1ns/10ps

module vmul_result_queue (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  vmul_cfg_pkg::elen_t [3:0]            mul_result_i,
  input  logic [3:0]                           mul_valid_i,
  output logic [3:0]                           mul_ready_o,
  input  vmul_op_pkg::vinsn_t                  proc_vinsn_i,
  input  logic [vmul_cfg_pkg::VlWidth-1:0]     proc_remaining_i,
  output logic                                 write_fire_o,
  output vmul_op_pkg::result_t                 result_o,
  output logic                                 result_req_o,
  input  logic                                 result_gnt_i,
  output logic                                 commit_fire_o
);

  import vmul_cfg_pkg::*;
  import vmul_op_pkg::*;

  localparam int unsigned PntWidth = $clog2(ResultQueueDepth);

  result_t [ResultQueueDepth-1:0] queue_q;
  logic [PntWidth-1:0]            wr_pnt_q, rd_pnt_q;
  logic [PntWidth:0]              cnt_q;
  logic                           queue_full;
  logic [VlWidth-1:0]             nr_elems;
  logic [VlWidth-1:0]             nr_bytes;
  logic [VlWidth-1:0]             word_idx;
  logic [1:0]                     word_shift;
  result_t                        entry;

  assign queue_full = (cnt_q == ResultQueueDepth);

  // Words come out in instruction order, so only the processing width is drained
  always_comb begin
    mul_ready_o                    = '0;
    mul_ready_o[proc_vinsn_i.vsew] = !queue_full;
  end

  assign write_fire_o = mul_valid_i[proc_vinsn_i.vsew] && !queue_full;

  // Byte enable covers only the elements left in this word
  assign nr_elems = word_elems(proc_vinsn_i.vsew, proc_remaining_i);
  assign nr_bytes = nr_elems << proc_vinsn_i.vsew;

  // Word index within the instruction from the elements already processed
  assign word_shift = 2'(EW64) - 2'(proc_vinsn_i.vsew);
  assign word_idx   = (proc_vinsn_i.vl - proc_remaining_i) >> word_shift;

  assign entry.id    = proc_vinsn_i.id;
  assign entry.addr  = VrfAddrWidth'(proc_vinsn_i.vd * WordsPerReg + word_idx);
  assign entry.wdata = mul_result_i[proc_vinsn_i.vsew];
  assign entry.be    = ~({StrbWidth{1'b1}} << nr_bytes);

  assign result_req_o  = (cnt_q != '0);
  assign result_o      = queue_q[rd_pnt_q];
  assign commit_fire_o = result_req_o && result_gnt_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (write_fire_o) wr_pnt_q <= wr_pnt_q + 1'b1;
      if (commit_fire_o) rd_pnt_q <= rd_pnt_q + 1'b1;
      case ({write_fire_o, commit_fire_o})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (write_fire_o) queue_q[wr_pnt_q] <= entry;
  end

endmodule

// File: design/vmul_unit.sv
// Vector lane multiply unit top level
`timescale 1ns/10ps

module vmul_unit (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  vmul_op_pkg::vinsn_t               vinsn_i,
  input  logic                              vinsn_valid_i,
  output logic                              vinsn_ready_o,
  input  vmul_op_pkg::operand_t             operand_i,
  input  logic                              operand_valid_i,
  output logic                              operand_ready_o,
  output vmul_op_pkg::result_t              result_o,
  output logic                              result_req_o,
  input  logic                              result_gnt_i,
  output logic [vmul_cfg_pkg::NrVInsn-1:0]  done_o
);

  import vmul_cfg_pkg::*;
  import vmul_op_pkg::*;

  vinsn_t             issue_vinsn;
  vinsn_t             proc_vinsn;
  logic               issue_fire;
  logic               unit_ready;
  logic [VlWidth-1:0] proc_remaining;
  logic               write_fire;
  logic               commit_fire;
  mul_req_t           mul_req;
  logic [3:0]         mul_in_valid;
  logic [3:0]         mul_in_ready;
  elen_t [3:0]        mul_result;
  logic [3:0]         mul_out_valid;
  logic [3:0]         mul_out_ready;

  vmul_sequencer u_sequencer (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .vinsn_i          (vinsn_i),
    .vinsn_valid_i    (vinsn_valid_i),
    .vinsn_ready_o    (vinsn_ready_o),
    .operand_valid_i  (operand_valid_i),
    .operand_ready_o  (operand_ready_o),
    .unit_ready_i     (unit_ready),
    .issue_vinsn_o    (issue_vinsn),
    .issue_fire_o     (issue_fire),
    .proc_vinsn_o     (proc_vinsn),
    .proc_remaining_o (proc_remaining),
    .write_fire_i     (write_fire),
    .commit_fire_i    (commit_fire),
    .done_o           (done_o)
  );

  vmul_operand_stage u_operand_stage (
    .issue_vinsn_i (issue_vinsn),
    .issue_fire_i  (issue_fire),
    .operand_i     (operand_i),
    .mul_req_o     (mul_req),
    .mul_valid_o   (mul_in_valid),
    .mul_ready_i   (mul_in_ready),
    .unit_ready_o  (unit_ready)
  );

  // One multiplier per element width, indexed by the vsew encoding
  for (genvar i = 0; i < 4; i++) begin : gen_mul
    simd_mul #(
      .ElementWidth (vsew_e'(i))
    ) u_simd_mul (
      .clk_i    (clk_i),
      .rst_ni   (rst_ni),
      .req_i    (mul_req),
      .valid_i  (mul_in_valid[i]),
      .ready_o  (mul_in_ready[i]),
      .result_o (mul_result[i]),
      .valid_o  (mul_out_valid[i]),
      .ready_i  (mul_out_ready[i])
    );
  end

  vmul_result_queue u_result_queue (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .mul_result_i     (mul_result),
    .mul_valid_i      (mul_out_valid),
    .mul_ready_o      (mul_out_ready),
    .proc_vinsn_i     (proc_vinsn),
    .proc_remaining_i (proc_remaining),
    .write_fire_o     (write_fire),
    .result_o         (result_o),
    .result_req_o     (result_req_o),
    .result_gnt_i     (result_gnt_i),
    .commit_fire_o    (commit_fire)
  );

endmodule

// File: tests/vmul_unit_properties.sv
// Handshake properties of the multiply unit bound to its top level
`timescale 1ns/10ps

module vmul_unit_properties (
  input logic                             clk_i,
  input logic                             rst_ni,
  input vmul_op_pkg::result_t             result_o,
  input logic                             result_req_o,
  input logic                             result_gnt_i,
  input logic                             operand_valid_i,
  input logic                             operand_ready_o,
  input logic [vmul_cfg_pkg::NrVInsn-1:0] done_o
);

  // Oldest entry stays put until it is granted
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_req_o && !result_gnt_i |=> result_req_o && $stable(result_o))
    else $error("result_o changed while waiting for a grant");

  // A done pulse marks a granted word
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(done_o) && ((done_o == '0) || (result_req_o && result_gnt_i)))
    else $error("done_o has more than one bit set or pulsed without a grant");

  assert property (@(posedge clk_i) disable iff (!rst_ni) operand_ready_o |-> operand_valid_i)
    else $error("operand_ready_o raised without operand_valid_i");

endmodule

bind vmul_unit vmul_unit_properties u_properties (
  .clk_i           (clk_i),
  .rst_ni          (rst_ni),
  .result_o        (result_o),
  .result_req_o    (result_req_o),
  .result_gnt_i    (result_gnt_i),
  .operand_valid_i (operand_valid_i),
  .operand_ready_o (operand_ready_o),
  .done_o          (done_o)
);

// File: tests/tb_vmul_unit.sv
// Table-driven testbench for the vector lane multiply unit with a reference model
`timescale 1ns/10ps

module tb_vmul_unit;

  import vmul_cfg_pkg::*;
  import vmul_op_pkg::*;

  localparam int unsigned NrTests     = 10;
  localparam int unsigned SettleDelay = 10;
  localparam int unsigned HoldCycles  = 30;

  typedef struct packed {
    vmul_op_e           op;
    vsew_e              vsew;
    logic [VlWidth-1:0] vl;
    logic               use_scalar;
    elen_t              scalar;
  } stim_t;

  typedef struct packed {
    result_t res;
    logic    last;
  } expect_t;

  logic             clk_i = 1'b0;
  logic             rst_ni;
  vinsn_t           vinsn_i;
  logic             vinsn_valid_i;
  logic             vinsn_ready_o;
  operand_t         operand_i;
  logic             operand_valid_i;
  logic             operand_ready_o;
  result_t          result_o;
  logic             result_req_o;
  logic             result_gnt_i;
  logic [NrVInsn-1:0] done_o;

  stim_t       stim_tab [NrTests];
  expect_t     exp_q [$];
  integer      seed;
  int unsigned cycle_cnt;
  int unsigned timeout_cycles;
  int unsigned total_words;
  int unsigned outstanding;
  int unsigned n_done;
  logic        saw_full;

  vmul_unit u_dut (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .vinsn_i         (vinsn_i),
    .vinsn_valid_i   (vinsn_valid_i),
    .vinsn_ready_o   (vinsn_ready_o),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_ready_o (operand_ready_o),
    .result_o        (result_o),
    .result_req_o    (result_req_o),
    .result_gnt_i    (result_gnt_i),
    .done_o          (done_o)
  );

  always #50 clk_i = ~clk_i;

  task automatic check_value(input logic [127:0] actual, input logic [127:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t ns: %s, got %0h, expected %0h", $time, what, actual,
               expected);
      $display("FAIL: see errors above");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // Per-lane result of one word computed on zero-extended 128-bit values
  function automatic elen_t ref_word(vmul_op_e op, vsew_e vsew, logic use_scalar,
                                     elen_t scalar, elen_t a, elen_t b, elen_t c);
    int unsigned  ew;
    logic [127:0] mask;
    logic [127:0] ea;
    logic [127:0] eb;
    logic [127:0] ec;
    logic [127:0] prod;
    logic [127:0] lane;
    elen_t        res;
    ew   = 8 << vsew;
    mask = (128'd1 << ew) - 128'd1;
    res  = '0;
    for (int k = 0; k < int'(64 / ew); k++) begin
      ea   = use_scalar ? (128'(scalar) & mask) : ((128'(a) >> (k * ew)) & mask);
      eb   = (128'(b) >> (k * ew)) & mask;
      ec   = (128'(c) >> (k * ew)) & mask;
      prod = ea * eb;
      case (op)
        VMULHU:  lane = (prod >> ew) & mask;
        VMACC:   lane = (ec + prod) & mask;
        default: lane = prod & mask;
      endcase
      res = res | 64'(lane << (k * ew));
    end
    return res;
  endfunction

  function automatic strb_t byte_enable(vsew_e vsew, int unsigned n);
    int unsigned bytes;
    bytes = n << vsew;
    return (bytes >= 8) ? 8'hff : strb_t'((1 << bytes) - 1);
  endfunction

  function automatic elen_t random_word();
    elen_t w;
    w[63:32] = $random(seed);
    w[31:0]  = $random(seed);
    return w;
  endfunction

  function automatic logic [4:0] vd_of(int unsigned i);
    return 5'(3 * i + 1);
  endfunction

  task automatic drive_instructions();
    vinsn_t v;
    for (int unsigned i = 0; i < NrTests; i++) begin
      @(negedge clk_i);
      v.id         = 3'(i);
      v.op         = stim_tab[i].op;
      v.vsew       = stim_tab[i].vsew;
      v.vl         = stim_tab[i].vl;
      v.vd         = vd_of(i);
      v.use_scalar = stim_tab[i].use_scalar;
      v.scalar_op  = stim_tab[i].scalar;
      vinsn_i       = v;
      vinsn_valid_i = 1'b1;
      #SettleDelay;
      while (!vinsn_ready_o) begin
        @(negedge clk_i);
        #SettleDelay;
      end
    end
    @(negedge clk_i);
    vinsn_valid_i = 1'b0;
  endtask

  // Presents operand words and queues the expected write for each consumed word
  task automatic drive_operands();
    stim_t       s;
    int unsigned rem;
    int unsigned per;
    int unsigned n;
    int unsigned widx;
    expect_t     e;
    for (int unsigned i = 0; i < NrTests; i++) begin
      s    = stim_tab[i];
      rem  = s.vl;
      per  = 8 >> s.vsew;
      widx = 0;
      while (rem != 0) begin
        n = (rem < per) ? rem : per;
        @(negedge clk_i);
        operand_i.vs1   = random_word();
        operand_i.vs2   = random_word();
        operand_i.vd    = random_word();
        operand_valid_i = 1'b1;
        #SettleDelay;
        while (!operand_ready_o) begin
          @(negedge clk_i);
          #SettleDelay;
        end
        e.res.id    = 3'(i);
        e.res.addr  = 8'(vd_of(i) * WordsPerReg + widx);
        e.res.wdata = ref_word(s.op, s.vsew, s.use_scalar, s.scalar, operand_i.vs1,
                               operand_i.vs2, operand_i.vd);
        e.res.be    = byte_enable(s.vsew, n);
        e.last      = (rem == n);
        exp_q.push_back(e);
        rem  = rem - n;
        widx = widx + 1;
      end
    end
    @(negedge clk_i);
    operand_valid_i = 1'b0;
  endtask

  // Random grant pattern that stays closed at the start so the queues fill
  task automatic grant_results();
    int unsigned granted;
    logic        allow;
    expect_t     e;
    granted = 0;
    allow   = 1'b0;
    while (granted < total_words) begin
      @(negedge clk_i);
      result_gnt_i = result_req_o && allow;
      #SettleDelay;
      if (result_gnt_i) begin
        if (exp_q.size() == 0) begin
          $display("Result offered at %0t ns while no result was expected", $time);
          $display("FAIL: see errors above");
          $fatal(1, "unexpected result");
        end
        e = exp_q.pop_front();
        check_value(result_o.id, e.res.id, "result id");
        check_value(result_o.addr, e.res.addr, "result address");
        check_value(result_o.be, e.res.be, $sformatf("byte enable at addr %0d", e.res.addr));
        check_value(result_o.wdata, e.res.wdata, $sformatf("wdata at addr %0d", e.res.addr));
        check_value(done_o, e.last ? (128'd1 << e.res.id) : 128'd0, "done_o on grant");
        granted++;
      end else begin
        check_value(done_o, 128'd0, "done_o without grant");
      end
      allow = (cycle_cnt >= HoldCycles) && (($random(seed) & 3) != 0);
    end
    @(negedge clk_i);
    result_gnt_i = 1'b0;
  endtask

  // Instructions in flight against the accept handshake
  always @(negedge clk_i) begin
    #SettleDelay;
    if (rst_ni) begin
      check_value(vinsn_ready_o, outstanding != VInsnQueueDepth, "vinsn_ready_o vs in flight");
      if (!vinsn_ready_o) saw_full = 1'b1;
      if (vinsn_valid_i && vinsn_ready_o) outstanding++;
      if (done_o != '0) begin
        outstanding--;
        n_done++;
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= timeout_cycles) begin
      $display("Timeout after %0d cycles, results or done pulses are missing", cycle_cnt);
      $display("FAIL: see errors above");
      $fatal(1, "timeout");
    end
  end

  initial begin
    seed            = 32'h491e23bc;
    rst_ni          = 1'b0;
    vinsn_i         = '0;
    vinsn_valid_i   = 1'b0;
    operand_i       = '0;
    operand_valid_i = 1'b0;
    result_gnt_i    = 1'b0;
    cycle_cnt       = 0;
    outstanding     = 0;
    n_done          = 0;
    saw_full        = 1'b0;
    // op, vsew, vl, use_scalar, scalar
    stim_tab[0] = '{VMUL,   EW8,  7'd16, 1'b0, 64'h0};
    stim_tab[1] = '{VMUL,   EW16, 7'd8,  1'b0, 64'h0};
    stim_tab[2] = '{VMUL,   EW32, 7'd4,  1'b0, 64'h0};
    stim_tab[3] = '{VMUL,   EW64, 7'd2,  1'b0, 64'h0};
    stim_tab[4] = '{VMULHU, EW8,  7'd13, 1'b0, 64'h0};
    stim_tab[5] = '{VMULHU, EW64, 7'd3,  1'b0, 64'h0};
    stim_tab[6] = '{VMACC,  EW16, 7'd6,  1'b1, 64'h0000_0000_0000_b7c3};
    stim_tab[7] = '{VMACC,  EW32, 7'd3,  1'b0, 64'h0};
    stim_tab[8] = '{VMUL,   EW8,  7'd20, 1'b1, 64'h0000_0000_0000_00e9};
    stim_tab[9] = '{VMULHU, EW32, 7'd5,  1'b1, 64'h0000_0000_f1d2_3a47};
    total_words = 0;
    for (int unsigned i = 0; i < NrTests; i++) begin
      total_words += (stim_tab[i].vl + (8 >> stim_tab[i].vsew) - 1) / (8 >> stim_tab[i].vsew);
    end
    timeout_cycles = 40 * total_words + 200;
    @(negedge clk_i);
    #SettleDelay;
    // Outputs while reset is held
    check_value(vinsn_ready_o, 1'b1, "vinsn_ready_o in reset");
    check_value(result_req_o, 1'b0, "result_req_o in reset");
    check_value(operand_ready_o, 1'b0, "operand_ready_o in reset");
    check_value(done_o, 128'd0, "done_o in reset");
    @(negedge clk_i);
    rst_ni = 1'b1;
    fork
      drive_instructions();
      drive_operands();
      grant_results();
    join
    #SettleDelay;
    check_value(result_req_o, 1'b0, "result_req_o still high after the last grant");
    check_value(saw_full, 1'b1, "vinsn_ready_o never fell with four in flight");
    check_value(n_done, NrTests, "number of done pulses");
    $display("PASS: all tests");
    $finish;
  end

endmodule

// File: vmul_unit.f
design/vmul_cfg_pkg.sv
design/vmul_op_pkg.sv
design/vmul_sequencer.sv
design/vmul_operand_stage.sv
design/simd_mul.sv
design/vmul_result_queue.sv
design/vmul_unit.sv
tests/vmul_unit_properties.sv
tests/tb_vmul_unit.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the multiply unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_vmul_unit -f vmul_unit.f -o sim_tb_vmul_unit

status=0
./obj_dir/sim_tb_vmul_unit > sim.log 2>&1 || status=$?
cat sim.log

if grep -qx "PASS: all tests" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, exit status $status"
  exit 1
fi
